//--- source/fir_pkg.sv
package fir_pkg;

    // Filter geometry
    localparam int FIR_NUM_TAPS    = 8;
    localparam int FIR_COEFF_WIDTH = 16;   // Q1.15 fractions, sum scaled by >>> 16
    localparam int FIR_ADDR_WIDTH  = 3;    // Selects one of eight taps
    localparam int FIR_GUARD_BITS  = 3;    // log2(8) headroom for the product sum

    // One signed coefficient
    typedef logic signed [FIR_COEFF_WIDTH-1:0] fir_coeff_t;

    // Preset selector
    typedef enum logic {
        FIR_LOW_PASS  = 1'b0,
        FIR_HIGH_PASS = 1'b1
    } fir_shape_e;

    // Tapered symmetric low-pass set, also the reset contents
    localparam fir_coeff_t FIR_LOW_PASS_TABLE [FIR_NUM_TAPS] = '{
        16'h0400, 16'h0800, 16'h0C00, 16'h1000,
        16'h1000, 16'h0C00, 16'h0800, 16'h0400
    };

    // Symmetric high-pass set, negative outer taps
    localparam fir_coeff_t FIR_HIGH_PASS_TABLE [FIR_NUM_TAPS] = '{
        16'hFC00, 16'hF800, 16'h0400, 16'h0800,
        16'h0800, 16'h0400, 16'hF800, 16'hFC00
    };

endpackage

//--- source/fir_coeff_regs.sv
`timescale 1ns/10ps

module fir_coeff_regs (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // Single-tap write port
    input  logic                                 coeff_wr,          // One-cycle write strobe
    input  logic [fir_pkg::FIR_ADDR_WIDTH-1:0]   coeff_addr,        // Write and readback address
    input  fir_pkg::fir_coeff_t                  coeff_wdata,
    // Preset load
    input  logic                                 coeff_preset,      // One-cycle load strobe
    input  fir_pkg::fir_shape_e                  coeff_preset_sel,
    // Readback and filter side
    output fir_pkg::fir_coeff_t                  coeff_rdata,
    output logic [fir_pkg::FIR_NUM_TAPS*fir_pkg::FIR_COEFF_WIDTH-1:0] coeffs
);

    import fir_pkg::*;

    // Coefficient storage, index 0 pairs with the newest sample
    fir_coeff_t bank [FIR_NUM_TAPS];

    // Preset table chosen by the selector
    fir_coeff_t preset_tbl [FIR_NUM_TAPS];

    always_comb begin
        case (coeff_preset_sel)
            FIR_LOW_PASS:  preset_tbl = FIR_LOW_PASS_TABLE;
            FIR_HIGH_PASS: preset_tbl = FIR_HIGH_PASS_TABLE;
            default:       preset_tbl = FIR_LOW_PASS_TABLE;   // Unknown select falls back
        endcase
    end

    // Bank update
    // Preset wins over a write, though the two never coincide
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < FIR_NUM_TAPS; i++) begin
                bank[i] <= FIR_LOW_PASS_TABLE[i];   // Come up as low-pass
            end
        end else if (coeff_preset) begin
            for (int i = 0; i < FIR_NUM_TAPS; i++) begin
                bank[i] <= preset_tbl[i];           // Whole bank in one edge
            end
        end else if (coeff_wr) begin
            bank[coeff_addr] <= coeff_wdata;        // Only the addressed tap
        end
    end

    // Combinational readback of the addressed tap
    assign coeff_rdata = bank[coeff_addr];

    // Flat view for the product stage, tap k in slice k
    genvar k;
    generate
        for (k = 0; k < FIR_NUM_TAPS; k++) begin : g_flat
            assign coeffs[k*FIR_COEFF_WIDTH +: FIR_COEFF_WIDTH] = bank[k];
        end
    endgenerate

    // Host never issues a preset and a single-tap write together
    a_no_wr_during_preset : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(coeff_wr && coeff_preset)
    ) else $error("coeff_wr and coeff_preset both high");

endmodule

//--- source/fir_tap_line.sv
`timescale 1ns/10ps

module fir_tap_line #(
    parameter int DATA_WIDTH = 16                   // Sample width
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [DATA_WIDTH-1:0]                      data_in,      // New sample
    input  logic                                       data_valid,   // Qualifies data_in
    output logic [fir_pkg::FIR_NUM_TAPS*DATA_WIDTH-1:0] taps,        // Window, tap 0 newest
    output logic                                       window_valid  // New window this cycle
);

    import fir_pkg::*;

    // Delay line, slot 0 holds the latest sample
    logic [DATA_WIDTH-1:0] line_q [FIR_NUM_TAPS];

    // Shift only on a valid sample
    // Samples before reset count as zero, so the line is cleared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < FIR_NUM_TAPS; i++) begin
                line_q[i] <= '0;
            end
            window_valid <= 1'b0;
        end else begin
            window_valid <= data_valid;             // One cycle after the sampling edge
            if (data_valid) begin
                for (int i = FIR_NUM_TAPS-1; i > 0; i--) begin
                    line_q[i] <= line_q[i-1];       // Age every sample by one
                end
                line_q[0] <= data_in;
            end
        end
    end

    // Pack the window flat
    genvar k;
    generate
        for (k = 0; k < FIR_NUM_TAPS; k++) begin : g_taps
            assign taps[k*DATA_WIDTH +: DATA_WIDTH] = line_q[k];
        end
    endgenerate

    // A valid sample carries no X or Z into the window
    a_data_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        data_valid |-> !$isunknown(data_in)
    ) else $error("data_in unknown while data_valid high");

endmodule

//--- source/fir_mac_tree.sv
`timescale 1ns/10ps

module fir_mac_tree #(
    parameter int DATA_WIDTH = 16                   // Sample width
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [fir_pkg::FIR_NUM_TAPS*DATA_WIDTH-1:0] taps,         // Sample window
    input  logic                                       window_valid,
    input  logic [fir_pkg::FIR_NUM_TAPS*fir_pkg::FIR_COEFF_WIDTH-1:0] coeffs,
    output logic signed [DATA_WIDTH-1:0]               data_out,     // Scaled, clamped result
    output logic                                       data_out_valid
);

    import fir_pkg::*;

    // Widths through the datapath
    localparam int PROD_WIDTH = DATA_WIDTH + FIR_COEFF_WIDTH;
    localparam int ACC_WIDTH  = PROD_WIDTH + FIR_GUARD_BITS;   // Eight products fit

    // Clamp limits, sign extended to the accumulator width
    localparam logic signed [ACC_WIDTH-1:0] SAT_MAX =
        {{(ACC_WIDTH-DATA_WIDTH+1){1'b0}}, {(DATA_WIDTH-1){1'b1}}};
    localparam logic signed [ACC_WIDTH-1:0] SAT_MIN =
        {{(ACC_WIDTH-DATA_WIDTH+1){1'b1}}, {(DATA_WIDTH-1){1'b0}}};

    // Product stage
    logic signed [PROD_WIDTH-1:0] prod_q [FIR_NUM_TAPS];
    logic                         prod_valid;

    // Binary tree nodes, root at 1, leaves at FIR_NUM_TAPS and up
    logic signed [ACC_WIDTH-1:0] node [1:2*FIR_NUM_TAPS-1];

    logic signed [ACC_WIDTH-1:0]  sum_scaled;    // Sum after the fractional shift
    logic signed [DATA_WIDTH-1:0] sat_val;       // Clamped to the sample range

    // Stage 1, one multiply per tap with the coefficients of this cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < FIR_NUM_TAPS; i++) begin
                prod_q[i] <= '0;
            end
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= window_valid;
            if (window_valid) begin
                for (int i = 0; i < FIR_NUM_TAPS; i++) begin
                    // Both operands signed, full precision
                    prod_q[i] <= PROD_WIDTH'($signed(taps[i*DATA_WIDTH +: DATA_WIDTH]))
                               * PROD_WIDTH'($signed(coeffs[i*FIR_COEFF_WIDTH +: FIR_COEFF_WIDTH]));
                end
            end
        end
    end

    // Adder tree over the registered products
    always_comb begin
        for (int n = 0; n < FIR_NUM_TAPS; n++) begin
            node[FIR_NUM_TAPS+n] = ACC_WIDTH'(prod_q[n]);   // Sign extend into guard bits
        end
        for (int n = FIR_NUM_TAPS-1; n > 0; n--) begin
            node[n] = node[2*n] + node[2*n+1];              // Pairwise sum
        end
    end

    // Fractional scaling, then clamp
    always_comb begin
        sum_scaled = node[1] >>> FIR_COEFF_WIDTH;        // Arithmetic shift, truncates to -inf
        if (sum_scaled > SAT_MAX) begin
            sat_val = SAT_MAX[DATA_WIDTH-1:0];          // Positive overflow
        end else if (sum_scaled < SAT_MIN) begin
            sat_val = SAT_MIN[DATA_WIDTH-1:0];          // Negative overflow
        end else begin
            sat_val = sum_scaled[DATA_WIDTH-1:0];       // In range
        end
    end

    // Stage 2, output register, holds between valids
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out       <= '0;
            data_out_valid <= 1'b0;
        end else begin
            data_out_valid <= prod_valid;                // Single-cycle pulse per sample
            if (prod_valid) begin
                data_out <= sat_val;
            end
        end
    end

    // Every output pulse follows a product pulse
    a_out_after_prod : assert property (
        @(posedge clk) disable iff (!rst_n)
        data_out_valid |-> $past(prod_valid)
    ) else $error("data_out_valid without prod_valid one cycle earlier");

endmodule

//--- source/fir_filter_top.sv
`timescale 1ns/10ps

module fir_filter_top #(
    parameter int DATA_WIDTH = 16                   // Sample width, passed to the datapath
) (
    input  logic                               clk,
    input  logic                               rst_n,
    // Sample stream
    input  logic [DATA_WIDTH-1:0]              data_in,
    input  logic                               data_valid,
    output logic signed [DATA_WIDTH-1:0]       data_out,
    output logic                               data_out_valid,
    // Coefficient configuration
    input  logic                               coeff_wr,
    input  logic                               coeff_preset,
    input  fir_pkg::fir_shape_e                coeff_preset_sel,
    input  logic [fir_pkg::FIR_ADDR_WIDTH-1:0] coeff_addr,
    input  fir_pkg::fir_coeff_t                coeff_wdata,
    output fir_pkg::fir_coeff_t                coeff_rdata
);

    import fir_pkg::*;

    // Coefficient bank to product stage
    logic [FIR_NUM_TAPS*FIR_COEFF_WIDTH-1:0] coeffs;

    // Delay line to product stage
    logic [FIR_NUM_TAPS*DATA_WIDTH-1:0] taps;
    logic                               window_valid;

    // Coefficient registers, presets and readback
    fir_coeff_regs u_coeff_regs (
        .clk              (clk),
        .rst_n            (rst_n),
        .coeff_wr         (coeff_wr),
        .coeff_addr       (coeff_addr),
        .coeff_wdata      (coeff_wdata),
        .coeff_preset     (coeff_preset),
        .coeff_preset_sel (coeff_preset_sel),
        .coeff_rdata      (coeff_rdata),
        .coeffs           (coeffs)
    );

    // Last eight samples
    fir_tap_line #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_tap_line (
        .clk          (clk),
        .rst_n        (rst_n),
        .data_in      (data_in),
        .data_valid   (data_valid),
        .taps         (taps),
        .window_valid (window_valid)
    );

    // Products, sum, scale and clamp
    fir_mac_tree #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_mac_tree (
        .clk            (clk),
        .rst_n          (rst_n),
        .taps           (taps),
        .window_valid   (window_valid),
        .coeffs         (coeffs),
        .data_out       (data_out),
        .data_out_valid (data_out_valid)
    );

endmodule

//--- bench/fir_model.svh
`ifndef FIR_MODEL_SVH
`define FIR_MODEL_SVH

// Reference model of the filter, included in the testbench module body
// Uses DATA_WIDTH and the fir_pkg import of the including module

// Signed sample range as wide integers
localparam longint SAMPLE_MAX = (longint'(1) <<< (DATA_WIDTH - 1)) - 1;
localparam longint SAMPLE_MIN = -(longint'(1) <<< (DATA_WIDTH - 1));

fir_coeff_t                   model_coeff [FIR_NUM_TAPS];   // Mirror of the coefficient bank
logic signed [DATA_WIDTH-1:0] model_hist  [FIR_NUM_TAPS];   // Sample history, index 0 newest

// Pending results and the cycle each one is due in
logic signed [DATA_WIDTH-1:0] exp_value_q [$];
int                           exp_cycle_q [$];

// Power-up state: low-pass bank, empty history
function automatic void clear_model();
    for (int k = 0; k < FIR_NUM_TAPS; k++) begin
        model_coeff[k] = FIR_LOW_PASS_TABLE[k];
        model_hist[k]  = '0;                        // Samples before reset are zero
    end
    exp_value_q.delete();
    exp_cycle_q.delete();
endfunction

// Whole bank replaced by a preset
function automatic void load_model_preset(input fir_shape_e sel);
    for (int k = 0; k < FIR_NUM_TAPS; k++) begin
        model_coeff[k] = (sel == FIR_HIGH_PASS) ? FIR_HIGH_PASS_TABLE[k]
                                                : FIR_LOW_PASS_TABLE[k];
    end
endfunction

function automatic void write_model_tap(input int addr, input fir_coeff_t value);
    model_coeff[addr] = value;                      // Single tap only
endfunction

// Full-precision sum, shift by the coefficient width, clamp to the sample range
function automatic logic signed [DATA_WIDTH-1:0] expected_output();
    longint acc;
    longint scaled;
    acc = 0;
    for (int k = 0; k < FIR_NUM_TAPS; k++) begin
        acc = acc + longint'(model_hist[k]) * longint'(model_coeff[k]);
    end
    scaled = acc >>> FIR_COEFF_WIDTH;               // Rounds toward minus infinity
    if (scaled > SAMPLE_MAX) begin
        scaled = SAMPLE_MAX;
    end else if (scaled < SAMPLE_MIN) begin
        scaled = SAMPLE_MIN;
    end
    return DATA_WIDTH'(scaled);
endfunction

// New sample enters the history and queues its result
function automatic void push_sample(input logic signed [DATA_WIDTH-1:0] sample,
                                    input int due_cycle);
    for (int k = FIR_NUM_TAPS - 1; k > 0; k--) begin
        model_hist[k] = model_hist[k-1];
    end
    model_hist[0] = sample;
    exp_value_q.push_back(expected_output());
    exp_cycle_q.push_back(due_cycle);
endfunction

`endif

//--- bench/fir_tb.sv
`timescale 1ns/10ps

module fir_tb;

    import fir_pkg::*;

    localparam int DATA_WIDTH    = 16;
    localparam int HALF_PERIOD   = 50;             // 100 ns clock
    localparam int DRIVE_DELAY   = 5;              // Inputs settle after the rising edge
    localparam int RESET_CYCLES  = 8;
    localparam int SEED          = 63134;
    localparam int LATENCY       = 3;              // Drive cycle to output cycle
    localparam int STREAM_LEN    = 300;
    localparam int WR_STREAM_LEN = 100;
    localparam int SAT_LEN       = 16;             // Per polarity
    localparam int MAX_GAP       = 2;              // Idle cycles between samples
    localparam int TOTAL_SAMPLES = 2 * STREAM_LEN + WR_STREAM_LEN + 2 * SAT_LEN;
    // Worst-case stream length twice over, plus room for config and idle waits
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_SAMPLES * (MAX_GAP + 1) + 600;

    logic                          clk;
    logic                          rst_n;
    logic [DATA_WIDTH-1:0]         data_in;
    logic                          data_valid;
    logic signed [DATA_WIDTH-1:0]  data_out;
    logic                          data_out_valid;
    logic                          coeff_wr;
    logic                          coeff_preset;
    fir_shape_e                    coeff_preset_sel;
    logic [FIR_ADDR_WIDTH-1:0]     coeff_addr;
    fir_coeff_t                    coeff_wdata;
    fir_coeff_t                    coeff_rdata;

    int cycle_count       = 0;
    int error_count       = 0;
    int test_errors_start = 0;     // Error count when the current test began
    int tests_run         = 0;
    int tests_failed      = 0;

    logic signed [DATA_WIDTH-1:0] mon_value;       // Entry popped by the monitor
    int                           mon_cycle;

    `include "fir_model.svh"

    fir_filter_top #(
        .DATA_WIDTH (DATA_WIDTH)
    ) dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .data_in          (data_in),
        .data_valid       (data_valid),
        .data_out         (data_out),
        .data_out_valid   (data_out_valid),
        .coeff_wr         (coeff_wr),
        .coeff_preset     (coeff_preset),
        .coeff_preset_sel (coeff_preset_sel),
        .coeff_addr       (coeff_addr),
        .coeff_wdata      (coeff_wdata),
        .coeff_rdata      (coeff_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Output checker, sampled mid-cycle where data_out is stable
    always @(negedge clk) begin
        if (rst_n && data_out_valid) begin
            assert (exp_value_q.size() != 0) else begin
                $display("Unexpected output at %0t: data_out_valid high with no sample pending",
                         $time);
                error_count++;
            end
            if (exp_value_q.size() != 0) begin
                mon_value = exp_value_q.pop_front();
                mon_cycle = exp_cycle_q.pop_front();
                assert (cycle_count == mon_cycle) else begin
                    $display("Error at %0t: data_out_valid cycle expected %0d, got %0d",
                             $time, mon_cycle, cycle_count);
                    error_count++;
                end
                assert (data_out == mon_value) else begin
                    $display("Error at %0t: data_out expected %0d, got %0d",
                             $time, mon_value, data_out);
                    error_count++;
                end
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic compare_readback(input int addr, input fir_coeff_t expected);
        @(negedge clk);                             // Readback is combinational
        assert (coeff_rdata == expected) else begin
            $display("Error at %0t: coeff_rdata[%0d] expected %h, got %h",
                     $time, addr, expected, coeff_rdata);
            error_count++;
        end
    endtask

    // Read all taps and compare with a preset table
    task automatic check_bank(input fir_shape_e sel);
        for (int a = 0; a < FIR_NUM_TAPS; a++) begin
            step();
            coeff_addr = FIR_ADDR_WIDTH'(a);
            compare_readback(a, (sel == FIR_HIGH_PASS) ? FIR_HIGH_PASS_TABLE[a]
                                                       : FIR_LOW_PASS_TABLE[a]);
        end
    endtask

    task automatic load_preset(input fir_shape_e sel);
        step();
        coeff_preset_sel = sel;
        coeff_preset     = 1'b1;
        load_model_preset(sel);
        step();
        coeff_preset     = 1'b0;                    // One-cycle strobe
    endtask

    // One-cycle write, then readback with the address held
    task automatic write_coeff(input int addr, input fir_coeff_t value);
        step();
        coeff_wr    = 1'b1;
        coeff_addr  = FIR_ADDR_WIDTH'(addr);
        coeff_wdata = value;
        write_model_tap(addr, value);
        step();
        coeff_wr    = 1'b0;
        compare_readback(addr, value);
    endtask

    // Samples with random idle gaps, zero gap gives back-to-back runs
    task automatic drive_stream(input int count, input bit use_fixed,
                                input logic signed [DATA_WIDTH-1:0] fixed_value);
        logic signed [DATA_WIDTH-1:0] sample;
        int gap;
        for (int i = 0; i < count; i++) begin
            sample = use_fixed ? fixed_value : DATA_WIDTH'($urandom);
            step();
            data_in    = sample;
            data_valid = 1'b1;
            push_sample(sample, cycle_count + LATENCY);
            gap = $urandom_range(0, MAX_GAP);
            repeat (gap) begin
                step();
                data_valid = 1'b0;
                data_in    = DATA_WIDTH'($urandom);  // Junk while idle
            end
        end
        step();
        data_valid = 1'b0;
    endtask

    // Drain the pipeline within a bounded wait, then keep three quiet cycles
    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_value_q.size() != 0 && waited < 2 * LATENCY) begin
            step();
            waited++;
        end
        assert (exp_value_q.size() == 0) else begin
            $display("Missing outputs at %0t: %0d expected results never appeared",
                     $time, exp_value_q.size());
            error_count++;
            exp_value_q.delete();
            exp_cycle_q.delete();
        end
        repeat (3) step();
    endtask

    task automatic check_output_value(input logic signed [DATA_WIDTH-1:0] expected);
        assert (data_out == expected) else begin
            $display("Error at %0t: data_out expected %0d, got %0d", $time, expected, data_out);
            error_count++;
        end
    endtask

    task automatic check_output_quiet();
        assert (data_out_valid == 1'b0) else begin
            $display("Error at %0t: data_out_valid expected 0, got %b", $time, data_out_valid);
            error_count++;
        end
        check_output_value('0);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_count == test_errors_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - test_errors_start);
        end
        test_errors_start = error_count;
    endtask

    initial begin
        rst_n            = 1'b0;
        data_in          = '0;
        data_valid       = 1'b0;
        coeff_wr         = 1'b0;
        coeff_preset     = 1'b0;
        coeff_preset_sel = FIR_LOW_PASS;
        coeff_addr       = '0;
        coeff_wdata      = '0;
        void'($urandom(SEED));
        clear_model();

        // Reset state, outputs quiet during and after reset
        repeat (RESET_CYCLES) begin
            step();
            check_output_quiet();
        end
        rst_n = 1'b1;
        step();
        check_output_quiet();
        check_bank(FIR_LOW_PASS);
        end_test("reset_state");

        drive_stream(STREAM_LEN, 1'b0, '0);         // Low-pass from reset
        wait_idle();
        end_test("low_pass_stream");

        load_preset(FIR_HIGH_PASS);
        check_bank(FIR_HIGH_PASS);
        drive_stream(STREAM_LEN, 1'b0, '0);
        wait_idle();
        end_test("high_pass_preset");

        for (int a = 0; a < FIR_NUM_TAPS; a++) begin
            write_coeff(a, FIR_COEFF_WIDTH'($urandom));
        end
        drive_stream(WR_STREAM_LEN, 1'b0, '0);
        wait_idle();
        end_test("single_tap_writes");

        // Largest coefficients with full-scale samples of each sign
        for (int a = 0; a < FIR_NUM_TAPS; a++) begin
            write_coeff(a, 16'sh7FFF);
        end
        drive_stream(SAT_LEN, 1'b1, DATA_WIDTH'(SAMPLE_MAX));
        wait_idle();
        check_output_value(DATA_WIDTH'(SAMPLE_MAX));   // Held at the clamp
        drive_stream(SAT_LEN, 1'b1, DATA_WIDTH'(SAMPLE_MIN));
        wait_idle();
        check_output_value(DATA_WIDTH'(SAMPLE_MIN));
        end_test("saturation");

        $display("%0d tests run, %0d ok, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+bench
source/fir_pkg.sv
source/fir_coeff_regs.sv
source/fir_tap_line.sv
source/fir_mac_tree.sv
source/fir_filter_top.sv
bench/fir_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the FIR testbench with Verilator, run it, and report pass or fail
set -u

cd "$(dirname "$0")" || exit 1

TOP=fir_tb
BUILD_DIR=obj_dir

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found on PATH"
    exit 1
fi

# Compile with assertions and timing support
verilator --binary --assert --timing -f all.f --top-module "$TOP" \
    -Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Run and keep the output in memory
output=$("./$BUILD_DIR/$TOP" 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
